/* logic/mem_bus_pkg.sv */
//////////////////////////////////////////////////////////////////////
// memory bus definitions
// widths and vector types for the req/gnt/rvalid data bus
//////////////////////////////////////////////////////////////////////

package mem_bus_pkg;

  // bus geometry
  localparam int unsigned BusAddrWidth = 32;
  localparam int unsigned BusDataWidth = 32;
  localparam int unsigned BusBeWidth   = 4;

  // low address bits dropped when forming a word address
  localparam int unsigned WordOffsetBits = 2;

  // word address, always word aligned on the bus
  typedef logic [BusAddrWidth-1:0] bus_addr_t;
  // one data word
  typedef logic [BusDataWidth-1:0] bus_data_t;
  // one enable per byte lane
  typedef logic [BusBeWidth-1:0]   bus_be_t;

endpackage

/* logic/lsu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// load/store unit definitions
// access size codes, byte offset and controller states
//////////////////////////////////////////////////////////////////////

package lsu_pkg;

  // access size as driven by the execute stage
  // both byte codes are handled identically
  typedef enum logic [1:0] {
    SizeWord    = 2'd0,
    SizeHalf    = 2'd1,
    SizeByte    = 2'd2,
    SizeByteAlt = 2'd3
  } lsu_size_e;

  // byte position inside a word
  typedef logic [1:0] byte_off_t;

  // bus controller states
  // Idle                  no access pending, or waiting for the last rvalid
  // WaitGntMis            first part of a split access waiting for grant
  // WaitRvalidMis         second part requested, first rvalid outstanding
  // WaitGnt               single or second part waiting for grant
  // WaitRvalidMisGntsDone both parts granted, first rvalid outstanding
  typedef enum logic [2:0] {
    Idle,
    WaitGntMis,
    WaitRvalidMis,
    WaitGnt,
    WaitRvalidMisGntsDone
  } ls_fsm_e;

  // upper three bytes of the first response kept for realignment
  localparam int unsigned UpperHoldBits = 24;

endpackage

/* logic/lsu_req_align.sv */
//////////////////////////////////////////////////////////////////////
// lsu request alignment
// word address, byte enables and store data rotation for each part
// of an access, plus detection of accesses that need two requests
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_req_align (
  input  mem_bus_pkg::bus_addr_t lsu_addr_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  mem_bus_pkg::bus_data_t lsu_wdata_i,
  input  logic                   second_part_i,
  output logic                   split_o,
  output mem_bus_pkg::bus_addr_t data_addr_o,
  output mem_bus_pkg::bus_be_t   data_be_o,
  output mem_bus_pkg::bus_data_t data_wdata_o,
  output lsu_pkg::byte_off_t     req_offset_o
);

  localparam int unsigned WordAddrBits =
      mem_bus_pkg::BusAddrWidth - mem_bus_pkg::WordOffsetBits;

  lsu_pkg::byte_off_t      offset;
  logic [WordAddrBits-1:0] word_addr;

  assign offset       = lsu_addr_i[mem_bus_pkg::WordOffsetBits-1:0];
  assign req_offset_o = offset;

  // word index bumped by one for the second part of a split
  assign word_addr   = lsu_addr_i[mem_bus_pkg::BusAddrWidth-1:mem_bus_pkg::WordOffsetBits]
                     + WordAddrBits'(second_part_i);
  assign data_addr_o = {word_addr, {mem_bus_pkg::WordOffsetBits{1'b0}}};

  // word crossing a word boundary, or halfword sitting in the top byte
  assign split_o = ((lsu_size_i == lsu_pkg::SizeWord) && (offset != 2'd0)) ||
                   ((lsu_size_i == lsu_pkg::SizeHalf) && (offset == 2'd3));

  ////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (lsu_size_i)
      lsu_pkg::SizeWord: begin
        // first part covers offset up to lane 3, second part the rest
        if (!second_part_i) begin
          data_be_o = 4'b1111 << offset;
        end else begin
          data_be_o = 4'b1111 >> (3'd4 - {1'b0, offset});
        end
      end
      lsu_pkg::SizeHalf: begin
        if (!second_part_i) begin
          // offset 3 leaves only lane 3 in the first word
          data_be_o = (offset == 2'd3) ? 4'b1000 : (4'b0011 << offset);
        end else begin
          data_be_o = 4'b0001;
        end
      end
      default: begin
        // bytes are never split
        data_be_o = 4'b0001 << offset;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // store data rotation
  ////////////////////////////////////////////////////////////////////

  // rotate left by the byte offset so byte 0 lands on lane offset
  // lanes that wrap around feed the second part
  always_comb begin
    unique case (offset)
      2'd1:    data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'd2:    data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      2'd3:    data_wdata_o = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
      default: data_wdata_o = lsu_wdata_i;
    endcase
  end

  // size drives split detection and enables, so it must be a known code
  always_comb begin
    size_known_a: assert final (!$isunknown(lsu_size_i))
      else $error("lsu access size unknown");
  end

endmodule

/* logic/lsu_bus_fsm.sv */
//////////////////////////////////////////////////////////////////////
// lsu bus controller
// sequences one or two bus requests per access, tracks the first
// response of a split access and reports bus errors
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_bus_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic lsu_req_i,
  input  logic lsu_we_i,
  input  logic split_i,
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_bus_err_i,
  output logic data_req_o,
  output logic second_part_o,
  output logic ctrl_update_o,
  output logic hold_first_o,
  output logic final_resp_o,
  output logic load_ok_o,
  output logic lsu_req_done_o,
  output logic lsu_resp_valid_o,
  output logic load_err_o,
  output logic store_err_o,
  output logic busy_o
);

  lsu_pkg::ls_fsm_e state_q, state_d;

  // direction of the access in flight
  logic we_q;
  // high while the second part is being requested
  logic second_q, second_d;
  // bus error seen on the first part of a split
  logic first_err_q, first_err_d;
  // first response of a split arrives this cycle
  logic first_rvalid;
  logic any_err;

  ////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    second_d      = second_q;
    first_err_d   = first_err_q;
    data_req_o    = 1'b0;
    ctrl_update_o = 1'b0;
    first_rvalid  = 1'b0;

    unique case (state_q)
      lsu_pkg::Idle: begin
        if (lsu_req_i) begin
          data_req_o  = 1'b1;
          first_err_d = 1'b0;
          if (data_gnt_i) begin
            ctrl_update_o = 1'b1;
            second_d      = split_i;
            state_d       = split_i ? lsu_pkg::WaitRvalidMis : lsu_pkg::Idle;
          end else begin
            state_d       = split_i ? lsu_pkg::WaitGntMis : lsu_pkg::WaitGnt;
          end
        end
      end

      lsu_pkg::WaitGntMis: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          second_d      = 1'b1;
          state_d       = lsu_pkg::WaitRvalidMis;
        end
      end

      lsu_pkg::WaitRvalidMis: begin
        // second request goes out while the first response is pending
        data_req_o = 1'b1;
        if (data_rvalid_i) begin
          first_rvalid = 1'b1;
          first_err_d  = data_bus_err_i;
          // granted now, only the final rvalid is left
          state_d      = data_gnt_i ? lsu_pkg::Idle : lsu_pkg::WaitGnt;
          second_d     = ~data_gnt_i;
        end else if (data_gnt_i) begin
          state_d  = lsu_pkg::WaitRvalidMisGntsDone;
          second_d = 1'b0;
        end
      end

      lsu_pkg::WaitGnt: begin
        data_req_o = 1'b1;
        if (data_gnt_i) begin
          ctrl_update_o = 1'b1;
          second_d      = 1'b0;
          state_d       = lsu_pkg::Idle;
        end
      end

      lsu_pkg::WaitRvalidMisGntsDone: begin
        // both requests out, collect the first response
        if (data_rvalid_i) begin
          first_rvalid = 1'b1;
          first_err_d  = data_bus_err_i;
          state_d      = lsu_pkg::Idle;
        end
      end

      default: begin
        state_d = lsu_pkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= lsu_pkg::Idle;
      second_q    <= 1'b0;
      first_err_q <= 1'b0;
      we_q        <= 1'b0;
    end else begin
      state_q     <= state_d;
      second_q    <= second_d;
      first_err_q <= first_err_d;
      if (ctrl_update_o) begin
        we_q <= lsu_we_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////

  assign second_part_o = second_q;
  assign busy_o        = (state_q != lsu_pkg::Idle);

  // first load bytes are only worth keeping for loads
  assign hold_first_o = first_rvalid & ~we_q;

  // any rvalid seen in Idle closes the access
  assign final_resp_o     = (state_q == lsu_pkg::Idle);
  assign lsu_resp_valid_o = data_rvalid_i & final_resp_o;

  // done once nothing is left to request
  assign lsu_req_done_o = (lsu_req_i | busy_o) & (state_d == lsu_pkg::Idle);

  // either part failing fails the access
  assign any_err     = first_err_q | data_bus_err_i;
  assign load_ok_o   = ~we_q & ~any_err;
  assign load_err_o  = lsu_resp_valid_o & any_err & ~we_q;
  assign store_err_o = lsu_resp_valid_o & any_err & we_q;

  state_legal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {lsu_pkg::Idle, lsu_pkg::WaitGntMis, lsu_pkg::WaitRvalidMis,
                    lsu_pkg::WaitGnt, lsu_pkg::WaitRvalidMisGntsDone})
    else $error("lsu controller in illegal state");

  // a request may not be withdrawn before it is granted
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o)
    else $error("lsu bus request dropped without grant");

endmodule

/* logic/lsu_rdata_align.sv */
//////////////////////////////////////////////////////////////////////
// lsu load data alignment
// joins both parts of a split load, realigns and extends the result
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_rdata_align (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   ctrl_update_i,
  input  logic                   hold_first_i,
  input  logic                   final_resp_i,
  input  logic                   load_ok_i,
  input  lsu_pkg::byte_off_t     req_offset_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  mem_bus_pkg::bus_data_t data_rdata_i,
  input  logic                   data_rvalid_i,
  output mem_bus_pkg::bus_data_t lsu_rdata_o,
  output logic                   lsu_rdata_valid_o
);

  // access control captured at grant
  lsu_pkg::byte_off_t offset_q;
  lsu_pkg::lsu_size_e size_q;
  logic               sign_ext_q;
  // bytes 1 to 3 of the first response
  logic [lsu_pkg::UpperHoldBits-1:0] upper_q;

  mem_bus_pkg::bus_data_t word_val;
  logic [15:0]            half_val;
  logic [7:0]             byte_val;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offset_q   <= '0;
      size_q     <= lsu_pkg::SizeWord;
      sign_ext_q <= 1'b0;
    end else if (ctrl_update_i) begin
      offset_q   <= req_offset_i;
      size_q     <= lsu_size_i;
      sign_ext_q <= lsu_sign_ext_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_first_i) begin
      upper_q <= data_rdata_i[mem_bus_pkg::BusDataWidth-1:8];
    end
  end

  ////////////////////////////////////////////////////////////////////
  // realignment
  ////////////////////////////////////////////////////////////////////

  // low bytes come from the held first word, high bytes from this one
  always_comb begin
    unique case (offset_q)
      2'd1:    word_val = {data_rdata_i[7:0],  upper_q[23:0]};
      2'd2:    word_val = {data_rdata_i[15:0], upper_q[23:8]};
      2'd3:    word_val = {data_rdata_i[23:0], upper_q[23:16]};
      default: word_val = data_rdata_i;
    endcase
  end

  // offset 3 is the split halfword
  always_comb begin
    unique case (offset_q)
      2'd1:    half_val = data_rdata_i[23:8];
      2'd2:    half_val = data_rdata_i[31:16];
      2'd3:    half_val = {data_rdata_i[7:0], upper_q[23:16]};
      default: half_val = data_rdata_i[15:0];
    endcase
  end

  assign byte_val = data_rdata_i[{offset_q, 3'b000} +: 8];

  // extend and pick by size
  always_comb begin
    unique case (size_q)
      lsu_pkg::SizeWord: lsu_rdata_o = word_val;
      lsu_pkg::SizeHalf: lsu_rdata_o = {{16{sign_ext_q & half_val[15]}}, half_val};
      default:           lsu_rdata_o = {{24{sign_ext_q & byte_val[7]}}, byte_val};
    endcase
  end

  // valid only on the last, error free load response
  assign lsu_rdata_valid_o = final_resp_i & data_rvalid_i & load_ok_i;

  ctrl_known_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown({offset_q, size_q}))
    else $error("lsu captured offset or size unknown");

endmodule

/* logic/lsu_top.sv */
//////////////////////////////////////////////////////////////////////
// load/store unit
// one access at a time from the core onto a req/gnt/rvalid data bus
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // core side
  input  logic                   lsu_req_i,
  input  logic                   lsu_we_i,
  input  lsu_pkg::lsu_size_e     lsu_size_i,
  input  logic                   lsu_sign_ext_i,
  input  mem_bus_pkg::bus_addr_t lsu_addr_i,
  input  mem_bus_pkg::bus_data_t lsu_wdata_i,
  output mem_bus_pkg::bus_data_t lsu_rdata_o,
  output logic                   lsu_rdata_valid_o,
  output logic                   lsu_resp_valid_o,
  output logic                   lsu_req_done_o,
  output logic                   load_err_o,
  output logic                   store_err_o,
  output logic                   busy_o,
  // bus side
  output logic                   data_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_bus_err_i,
  output mem_bus_pkg::bus_addr_t data_addr_o,
  output logic                   data_we_o,
  output mem_bus_pkg::bus_be_t   data_be_o,
  output mem_bus_pkg::bus_data_t data_wdata_o,
  input  mem_bus_pkg::bus_data_t data_rdata_i
);

  logic               split;
  logic               second_part;
  logic               ctrl_update;
  logic               hold_first;
  logic               final_resp;
  logic               load_ok;
  lsu_pkg::byte_off_t req_offset;

  // direction never changes within an access
  assign data_we_o = lsu_we_i;

  lsu_req_align u_req_align (
    .lsu_addr_i    (lsu_addr_i),
    .lsu_size_i    (lsu_size_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .second_part_i (second_part),
    .split_o       (split),
    .data_addr_o   (data_addr_o),
    .data_be_o     (data_be_o),
    .data_wdata_o  (data_wdata_o),
    .req_offset_o  (req_offset)
  );

  lsu_bus_fsm u_bus_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lsu_req_i        (lsu_req_i),
    .lsu_we_i         (lsu_we_i),
    .split_i          (split),
    .data_gnt_i       (data_gnt_i),
    .data_rvalid_i    (data_rvalid_i),
    .data_bus_err_i   (data_bus_err_i),
    .data_req_o       (data_req_o),
    .second_part_o    (second_part),
    .ctrl_update_o    (ctrl_update),
    .hold_first_o     (hold_first),
    .final_resp_o     (final_resp),
    .load_ok_o        (load_ok),
    .lsu_req_done_o   (lsu_req_done_o),
    .lsu_resp_valid_o (lsu_resp_valid_o),
    .load_err_o       (load_err_o),
    .store_err_o      (store_err_o),
    .busy_o           (busy_o)
  );

  lsu_rdata_align u_rdata_align (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .ctrl_update_i     (ctrl_update),
    .hold_first_i      (hold_first),
    .final_resp_i      (final_resp),
    .load_ok_i         (load_ok),
    .req_offset_i      (req_offset),
    .lsu_size_i        (lsu_size_i),
    .lsu_sign_ext_i    (lsu_sign_ext_i),
    .data_rdata_i      (data_rdata_i),
    .data_rvalid_i     (data_rvalid_i),
    .lsu_rdata_o       (lsu_rdata_o),
    .lsu_rdata_valid_o (lsu_rdata_valid_o)
  );

endmodule

/* verif/lsu_tb.sv */
//////////////////////////////////////////////////////////////////////
// lsu testbench
// random-latency memory model, reference load/store image and checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_tb;

  localparam int unsigned ErrWord         = 15;
  localparam int unsigned NumRandom       = 60;
  localparam int unsigned NumAccesses     = 32 + 24 + NumRandom + 6;
  // split access with worst grant and rvalid delays plus driver gaps
  localparam int unsigned MaxAccessCycles = 16;
  localparam int unsigned CycleLimit      = 10 * NumAccesses * MaxAccessCycles;
  localparam logic [31:0] LfsrTaps        = 32'h8020_0003;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   lsu_req_i, lsu_we_i, lsu_sign_ext_i;
  lsu_pkg::lsu_size_e     lsu_size_i;
  mem_bus_pkg::bus_addr_t lsu_addr_i;
  mem_bus_pkg::bus_data_t lsu_wdata_i, lsu_rdata_o;
  logic                   lsu_rdata_valid_o, lsu_resp_valid_o, lsu_req_done_o;
  logic                   load_err_o, store_err_o, busy_o;
  logic                   data_req_o, data_gnt_i, data_rvalid_i, data_bus_err_i, data_we_o;
  mem_bus_pkg::bus_addr_t data_addr_o;
  mem_bus_pkg::bus_be_t   data_be_o;
  mem_bus_pkg::bus_data_t data_wdata_o, data_rdata_i;

  // memory model state and the expected image
  logic [31:0] mem [16];
  logic [31:0] exp_mem [16];
  logic [31:0] rsp_data_q [$];
  logic        rsp_err_q [$];
  int unsigned rsp_due_q [$];
  logic [31:0] gnt_addr [2];
  logic [3:0]  word_idx;
  logic [31:0] rdata_next;
  logic        rvalid_next, err_next;
  int          gnt_wait, grants, overlap_cnt;

  // expected responses with one entry per access in flight
  string       exp_name_q [$];
  logic        exp_we_q [$];
  logic        exp_err_q [$];
  logic [31:0] exp_data_q [$];
  string       rsp_name;
  logic        rsp_we, rsp_err;
  logic [31:0] rsp_data;
  logic        done_flag = 1'b0;

  logic [31:0] lfsr_q = 32'hb887_c498;
  int unsigned cyc = 0;
  int          resp_cnt = 0;
  int          errors = 0;
  int          checks = 0;

  lsu_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // helpers and reference model
  ////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ({1'b0, s[31:1]} ^ LfsrTaps) : {1'b0, s[31:1]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // initial memory byte derived from the full byte address
  function automatic logic [7:0] fill_byte(input int a);
    return 8'(a * 37 + 131);
  endfunction

  function automatic logic [7:0] img_byte(input logic [31:0] a);
    return exp_mem[a[5:2]][{a[1:0], 3'b000} +: 8];
  endfunction

  function automatic int size_bytes(input lsu_pkg::lsu_size_e size);
    case (size)
      lsu_pkg::SizeWord: return 4;
      lsu_pkg::SizeHalf: return 2;
      default:           return 1;
    endcase
  endfunction

  // expected load value from little endian image bytes
  function automatic logic [31:0] ref_load(input logic [31:0] a, input lsu_pkg::lsu_size_e size,
                                           input logic sign);
    logic [31:0] w;
    w = {img_byte(a + 3), img_byte(a + 2), img_byte(a + 1), img_byte(a)};
    case (size)
      lsu_pkg::SizeWord: return w;
      lsu_pkg::SizeHalf: return {{16{sign & w[15]}}, w[15:0]};
      default:           return {{24{sign & w[7]}}, w[7:0]};
    endcase
  endfunction

  // error word never takes a write
  function automatic void apply_store(input logic [31:0] a, input lsu_pkg::lsu_size_e size,
                                      input logic [31:0] wdata);
    logic [31:0] b;
    for (int i = 0; i < size_bytes(size); i++) begin
      b = a + i;
      if (b[5:2] != ErrWord) begin
        exp_mem[b[5:2]][{b[1:0], 3'b000} +: 8] = wdata[8 * i +: 8];
      end
    end
  endfunction

  function automatic logic hits_err_word(input logic [31:0] a, input lsu_pkg::lsu_size_e size);
    logic [31:0] last;
    last = a + size_bytes(size) - 1;
    return (a[5:2] == ErrWord) || (last[5:2] == ErrWord);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // cycle limit
  ////////////////////////////////////////////////////////////////////

  initial begin
    while (cyc < CycleLimit) begin
      @(posedge clk_i);
      cyc++;
    end
    $display("timeout after %0d cycles, an access never completed", cyc);
    $display("%0d checks, %0d errors", checks, errors);
    $display("tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // memory model
  ////////////////////////////////////////////////////////////////////

  // handshakes sampled at negedge, next bus outputs applied at posedge
  initial begin
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_bus_err_i = 1'b0;
    data_rdata_i   = '0;
    gnt_wait       = 0;
    grants         = 0;
    overlap_cnt    = 0;
    for (int a = 0; a < 64; a++) begin
      mem[a >> 2][8 * (a & 3) +: 8] = fill_byte(a);
    end
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        rsp_data_q.delete();
        rsp_err_q.delete();
        rsp_due_q.delete();
      end else begin
        // head response consumed this cycle
        if (data_rvalid_i) begin
          void'(rsp_data_q.pop_front());
          void'(rsp_err_q.pop_front());
          void'(rsp_due_q.pop_front());
        end
        if (data_req_o && data_gnt_i) begin
          word_idx = data_addr_o[5:2];
          if (data_we_o && (word_idx != ErrWord)) begin
            for (int b = 0; b < 4; b++) begin
              if (data_be_o[b]) mem[word_idx][8 * b +: 8] = data_wdata_o[8 * b +: 8];
            end
          end
          rsp_data_q.push_back(mem[word_idx]);
          rsp_err_q.push_back(word_idx == ErrWord);
          rsp_due_q.push_back(cyc + 1 + (rand_bits(2) % 3));
          // earlier grant still waiting for its rvalid
          if (rsp_data_q.size() == 2) overlap_cnt++;
          if (rsp_data_q.size() > 2) begin
            errors++;
            $display("more than two bus requests outstanding at cycle %0d", cyc);
          end
          if (grants < 2) gnt_addr[grants] = data_addr_o;
          grants++;
          gnt_wait = rand_bits(2);
        end else if (data_req_o && (gnt_wait > 0)) begin
          gnt_wait--;
        end
      end
      rvalid_next = 1'b0;
      rdata_next  = '0;
      err_next    = 1'b0;
      if ((rsp_data_q.size() > 0) && (rsp_due_q[0] <= cyc + 1)) begin
        rvalid_next = 1'b1;
        rdata_next  = rsp_data_q[0];
        err_next    = rsp_err_q[0];
      end
      @(posedge clk_i);
      data_gnt_i     <= (gnt_wait == 0);
      data_rvalid_i  <= rvalid_next;
      data_rdata_i   <= rdata_next;
      data_bus_err_i <= err_next;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // response checker
  ////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (lsu_req_done_o) done_flag = 1'b1;
      if (lsu_resp_valid_o) begin
        if (exp_name_q.size() == 0) begin
          errors++;
          $display("response arrived with no access in flight");
        end else begin
          rsp_name = exp_name_q.pop_front();
          rsp_we   = exp_we_q.pop_front();
          rsp_err  = exp_err_q.pop_front();
          rsp_data = exp_data_q.pop_front();
          check_value({rsp_name, " done before response"}, 1, done_flag);
          check_value({rsp_name, " load_err"}, rsp_err && !rsp_we, load_err_o);
          check_value({rsp_name, " store_err"}, rsp_err && rsp_we, store_err_o);
          check_value({rsp_name, " rdata valid"}, !rsp_err && !rsp_we, lsu_rdata_valid_o);
          if (!rsp_we && !rsp_err) check_value({rsp_name, " rdata"}, rsp_data, lsu_rdata_o);
          check_value({rsp_name, " busy"}, 0, busy_o);
          resp_cnt++;
        end
        done_flag = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  // one access, held until done, then wait for its single response
  task automatic run_access(input string name, input logic we, input lsu_pkg::lsu_size_e size,
                            input logic sign, input logic [31:0] addr, input logic [31:0] wdata);
    int          start_cnt;
    logic        split;
    logic [31:0] last;
    last  = addr + size_bytes(size) - 1;
    // two requests whenever the accessed bytes reach into the next word
    split = (last[31:2] != addr[31:2]);
    exp_name_q.push_back(name);
    exp_we_q.push_back(we);
    exp_err_q.push_back(hits_err_word(addr, size));
    exp_data_q.push_back(ref_load(addr, size, sign));
    start_cnt = resp_cnt;
    @(posedge clk_i);
    grants         = 0;
    lsu_req_i      <= 1'b1;
    lsu_we_i       <= we;
    lsu_size_i     <= size;
    lsu_sign_ext_i <= sign;
    lsu_addr_i     <= addr;
    lsu_wdata_i    <= wdata;
    do @(negedge clk_i); while (!lsu_req_done_o);
    @(posedge clk_i);
    lsu_req_i <= 1'b0;
    wait (resp_cnt != start_cnt);
    @(posedge clk_i);
    // word aligned requests with the second one on the next word
    check_value({name, " grants"}, split ? 2 : 1, grants);
    check_value({name, " first address"}, {addr[31:2], 2'b00}, gnt_addr[0]);
    if (split) check_value({name, " second address"}, {addr[31:2], 2'b00} + 4, gnt_addr[1]);
    if (we) begin
      apply_store(addr, size, wdata);
      for (int i = 0; i < 16; i++) begin
        check_value($sformatf("%s word %0d", name, i), exp_mem[i], mem[i]);
      end
    end
  endtask

  initial begin
    logic [31:0]        addr;
    logic [31:0]        wdata;
    lsu_pkg::lsu_size_e size;
    logic               we;
    logic               sign;
    lsu_req_i      = 1'b0;
    lsu_we_i       = 1'b0;
    lsu_size_i     = lsu_pkg::SizeWord;
    lsu_sign_ext_i = 1'b0;
    lsu_addr_i     = '0;
    lsu_wdata_i    = '0;
    for (int a = 0; a < 64; a++) begin
      exp_mem[a >> 2][8 * (a & 3) +: 8] = fill_byte(a);
    end
    rst_ni = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    // quiet outputs with no request
    repeat (4) begin
      @(negedge clk_i);
      check_value("idle after reset", 0, {data_req_o, busy_o, lsu_req_done_o, lsu_resp_valid_o,
                                          lsu_rdata_valid_o, load_err_o, store_err_o});
    end

    // loads of every size code at every offset
    for (int sz = 0; sz < 4; sz++) begin
      for (int off = 0; off < 4; off++) begin
        for (int sg = 0; sg < 2; sg++) begin
          run_access($sformatf("load size %0d offset %0d sign %0d", sz, off, sg), 1'b0,
                     lsu_pkg::lsu_size_e'(sz), sg[0], 32'h08 + off, '0);
        end
      end
    end

    // stores then read back
    for (int sz = 0; sz < 3; sz++) begin
      for (int off = 0; off < 4; off++) begin
        wdata = rand_bits(32);
        run_access($sformatf("store size %0d offset %0d", sz, off), 1'b1,
                   lsu_pkg::lsu_size_e'(sz), 1'b0, 32'h14 + off, wdata);
        run_access($sformatf("reload size %0d offset %0d", sz, off), 1'b0,
                   lsu_pkg::lsu_size_e'(sz), 1'b0, 32'h14 + off, '0);
      end
    end

    // mixed random traffic over the whole model including the error word
    for (int n = 0; n < NumRandom; n++) begin
      addr  = rand_bits(6);
      size  = lsu_pkg::lsu_size_e'(rand_bits(2));
      we    = rand_bits(1);
      sign  = rand_bits(1);
      wdata = rand_bits(32);
      run_access($sformatf("random %0d", n), we, size, sign, addr, wdata);
    end

    // error word hit by either part
    run_access("error word load", 1'b0, lsu_pkg::SizeWord, 1'b0, 32'h3c, '0);
    run_access("error byte store", 1'b1, lsu_pkg::SizeByte, 1'b0, 32'h3e, 32'h0000_005a);
    run_access("error split load", 1'b0, lsu_pkg::SizeWord, 1'b0, 32'h3a, '0);
    run_access("error split store", 1'b1, lsu_pkg::SizeWord, 1'b0, 32'h3f, 32'hc3a5_5a3c);
    run_access("error split half load", 1'b0, lsu_pkg::SizeHalf, 1'b1, 32'h3b, '0);
    run_access("error split half store", 1'b1, lsu_pkg::SizeHalf, 1'b0, 32'h3b, 32'h0000_9e71);

    repeat (4) @(posedge clk_i);
    if (overlap_cnt == 0) begin
      errors++;
      $display("no second grant arrived before a first rvalid");
    end
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* lsu.f */
logic/mem_bus_pkg.sv
logic/lsu_pkg.sv
logic/lsu_req_align.sv
logic/lsu_bus_fsm.sv
logic/lsu_rdata_align.sv
logic/lsu_top.sv
verif/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - logic/mem_bus_pkg.sv
  - logic/lsu_pkg.sv
  - logic/lsu_req_align.sv
  - logic/lsu_bus_fsm.sv
  - logic/lsu_rdata_align.sv
  - logic/lsu_top.sv
  - target: test
    files:
      - verif/lsu_tb.sv
